// ==== Makefile ====
TOP = tb_tile_world
SRCS = $(shell grep -v '^+' tile_world.f) design/tile_cfg.svh

.PHONY: run clean

obj_dir/V$(TOP): tile_world.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f tile_world.f \
		--top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | awk '{ print } /^SIMULATION PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== bench/tb_tile_world.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module tb_tile_world
	import tile_pkg::*, bus_pkg::*;
();

	localparam int N_TESTS = 22;
	localparam int N_RANDOM = 256;
	localparam int WATCHDOG_CYCLES = N_TESTS * 10 + N_RANDOM * 2 + 300;
	localparam int OP_WR = 0;
	localparam int OP_RD = 1;
	localparam int OP_PIX = 2;
	localparam int OP_PLY = 3;
	localparam int OP_GATE = 4;

	logic clk, resetN, gate;
	coord_t pixel_x, pixel_y, player_x, player_y;
	logic wb_cyc, wb_stb, wb_we, wb_ack;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w, wb_dat_r;
	tile_t step_type;
	coord_t tile_top_left_x, tile_top_left_y;
	tile_t [3:0] area;	// {down, right, up, left}

	tile_t model [`TILE_ROWS][`TILE_COLS];	// expected map contents
	int t_op [N_TESTS];
	int t_a [N_TESTS];	// x or bus address
	int t_b [N_TESTS];	// y
	int t_dat [N_TESTS];
	int t_hold [N_TESTS];	// extra stb cycles after ack
	int t_exp [N_TESTS];
	int n_loaded = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	logic [31:0] seed = 32'hf3f9_792b;

	tile_world tile_world_inst (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("run timed out after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] r;
		r = s ^ (s << 13);
		r = r ^ (r >> 17);
		r = r ^ (r << 5);
		return r;
	endfunction

	function automatic tile_t expected_tile(input int x, input int y);
		int col;
		int row;
		col = x >> `TILE_SHIFT;
		row = y >> `TILE_SHIFT;
		if (col < `TILE_COLS && row < `TILE_ROWS)
			return model[row][col];
		return T_WALL;	// off the grid
	endfunction

	function automatic string op_name(input int op);
		case (op)
			OP_WR: return "bus write";
			OP_RD: return "bus read";
			OP_PIX: return "pixel probe";
			OP_PLY: return "player probe";
			default: return "gate overlay";
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		if (exp !== got) begin
			$display("ERR %s expected %h got %h at %0t", name, exp, got, $time);
			errors++;
		end
	endtask

	task automatic add_test(input int op, input int a, input int b, input int dat,
			input int hold, input int exp);
		t_op[n_loaded] = op;
		t_a[n_loaded] = a;
		t_b[n_loaded] = b;
		t_dat[n_loaded] = dat;
		t_hold[n_loaded] = hold;
		t_exp[n_loaded] = exp;
		n_loaded++;
	endtask

	task automatic load_level();
		model[0] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		model[1] = '{1, 0, 0, 0, 1, 0, 0, 0, 0, 0};
		model[2] = '{0, 0, 1, 0, 0, 0, 0, 0, 0, 0};
		model[3] = '{0, 1, 0, 1, 0, 1, 0, 1, 0, 1};
		model[4] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
		model[5] = '{1, 0, 0, 0, 0, 0, 0, 0, 1, 0};
		model[6] = '{0, 1, 1, 1, 0, 1, 0, 1, 0, 1};
	endtask

	task automatic load_table();
		add_test(OP_PIX, 5, 70, 0, 0, 1);
		add_test(OP_PIX, 300, 100, 0, 0, 1);
		add_test(OP_PIX, 170, 140, 0, 0, 1);
		add_test(OP_PIX, 639, 447, 0, 0, 1);	// last pixel of the grid
		add_test(OP_PIX, 100, 460, 0, 0, 4);	// below the grid
		add_test(OP_PLY, 10, 200, 0, 0, 12'o0104);	// column 0
		add_test(OP_PLY, 600, 200, 0, 0, 12'o0400);	// last column
		add_test(OP_PLY, 300, 20, 0, 0, 12'o1040);	// row 0
		add_test(OP_PLY, 200, 400, 0, 0, 12'o3001);	// bottom row
		add_test(OP_PLY, 150, 220, 0, 0, 12'o0111);	// interior
		add_test(OP_WR, 7'h25, 0, 8'hfb, 0, 0);	// upper data bits dropped
		add_test(OP_RD, 7'h25, 0, 0, 0, 8'h03);
		add_test(OP_PIX, 330, 150, 0, 0, 3);
		add_test(OP_WR, 7'h7a, 0, 8'h01, 0, 0);	// row 7 col 10
		add_test(OP_WR, 7'h0c, 0, 8'h01, 0, 0);	// row 0 col 12
		add_test(OP_RD, 7'h7a, 0, 0, 0, 8'h04);
		add_test(OP_RD, 7'h0c, 0, 0, 0, 8'h04);
		add_test(OP_PIX, 130, 70, 0, 0, 0);	// flat index of row 0 col 12
		add_test(OP_GATE, 0, 0, 0, 0, 0);
		add_test(OP_WR, 7'h33, 0, 8'h03, 5, 0);	// master holds stb
		add_test(OP_RD, 7'h33, 0, 0, 3, 8'h03);
		add_test(OP_PLY, 150, 220, 0, 0, 12'o0311);	// right neighbor rewritten
	endtask

	task automatic probe_pixel(input int x, input int y, input logic [31:0] exp);
		@(posedge clk);
		pixel_x <= coord_t'(x);
		pixel_y <= coord_t'(y);
		@(posedge clk);
		@(negedge clk);
		check_value("step_type", exp, step_type);
		check_value("tile_top_left_x", x - x % (1 << `TILE_SHIFT), tile_top_left_x);
		check_value("tile_top_left_y", y - y % (1 << `TILE_SHIFT), tile_top_left_y);
	endtask

	task automatic probe_player(input int x, input int y, input logic [31:0] exp);
		@(posedge clk);
		player_x <= coord_t'(x);
		player_y <= coord_t'(y);
		@(posedge clk);
		@(negedge clk);
		check_value("area", exp, area);
	endtask

	task automatic bus_xfer(input logic we, input int adr, input int dat, input int hold,
			input logic [31:0] exp);
		int acks;
		int writes;
		int waited;
		logic in_grid;
		logic [31:0] rdata;
		acks = 0;
		writes = 0;
		waited = 0;
		rdata = '0;
		in_grid = ((adr >> 4) < `TILE_ROWS) && ((adr & 15) < `TILE_COLS);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= we;
		wb_adr <= wb_adr_t'(adr);
		wb_dat_w <= wb_dat_t'(dat);
		while (acks == 0 && waited < 8) begin
			@(negedge clk);
			waited++;
			if (tile_world_inst.wr_en)
				writes++;
			if (wb_ack) begin
				acks++;
				rdata = wb_dat_r;
			end
		end
		if (acks == 0) begin
			$display("bus transfer to address %h was never acknowledged", adr);
			errors++;
		end
		repeat (hold + 2) begin	// held stb and then the drop
			if (hold > 0)
				hold--;
			else
				@(posedge clk) {wb_cyc, wb_stb, wb_we} <= 3'b000;
			@(negedge clk);
			if (tile_world_inst.wr_en)
				writes++;
			if (wb_ack)
				acks++;
		end
		@(negedge clk);
		check_value("wb_ack count", 1, acks);
		check_value("write strobes", (we && in_grid) ? 1 : 0, writes);
		if (!we)
			check_value("wb_dat_r", exp, rdata);
		if (we && in_grid)
			model[adr >> 4][adr & 15] = tile_t'(dat);
	endtask

	task automatic gate_test();
		int i;
		logic open_exp;
		logic drop_pending;
		tile_t exp_tile;
		drop_pending = 1'b0;
		@(posedge clk);
		pixel_x <= coord_t'(`GATE_COL * 64 + 10);
		pixel_y <= coord_t'(`GATE_ROW * 64 + 10);
		player_x <= coord_t'((`GATE_COL - 1) * 64 + 8);	// standing left of the gate
		player_y <= coord_t'(`GATE_ROW * 64 + 16);
		gate <= 1'b1;
		for (i = 0; i <= `GATE_HOLD_CYCLES + 2; i++) begin
			@(posedge clk);
			gate <= 1'b0;
			if (i == 4) begin	// rewrite the gate cell while open
				wb_cyc <= 1'b1;
				wb_stb <= 1'b1;
				wb_we <= 1'b1;
				wb_adr <= wb_adr_t'((`GATE_ROW << 4) | `GATE_COL);
				wb_dat_w <= wb_dat_t'(T_REGU);
			end else if (drop_pending) begin
				{wb_cyc, wb_stb, wb_we} <= 3'b000;
				drop_pending = 1'b0;
			end
			@(negedge clk);
			if (wb_ack) begin
				model[`GATE_ROW][`GATE_COL] = T_REGU;
				drop_pending = 1'b1;
			end
			open_exp = (i >= 1 && i <= `GATE_HOLD_CYCLES);	// registered view of gate_open
			exp_tile = open_exp ? T_GATE : model[`GATE_ROW][`GATE_COL];
			check_value("step_type", exp_tile, step_type);
			check_value("area_right", exp_tile, area[2]);
		end
	endtask

	initial begin
		int t;
		int err_before;
		int x;
		int y;
		resetN = 1'b0;
		gate = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		player_x = '0;
		player_y = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		load_level();
		load_table();
		repeat (8) @(posedge clk);
		resetN <= 1'b1;
		for (t = 0; t < N_TESTS; t++) begin
			err_before = errors;
			case (t_op[t])
				OP_WR: bus_xfer(1'b1, t_a[t], t_dat[t], t_hold[t], '0);
				OP_RD: bus_xfer(1'b0, t_a[t], 0, t_hold[t], t_exp[t]);
				OP_PIX: probe_pixel(t_a[t], t_b[t], t_exp[t]);
				OP_PLY: probe_player(t_a[t], t_b[t], t_exp[t]);
				default: gate_test();
			endcase
			if (errors == err_before)
				passed++;
			else
				failed++;
			$display("test %0d %s %s", t, op_name(t_op[t]), (errors == err_before) ? "ok" : "bad");
		end
		err_before = errors;
		for (t = 0; t < N_RANDOM; t++) begin
			seed = next_random(seed);
			x = int'(seed[31:16]) % 704;	// reaches one tile past the right edge
			y = int'(seed[15:0]) % 512;
			probe_pixel(x, y, expected_tile(x, y));
		end
		if (errors == err_before)
			passed++;
		else
			failed++;
		$display("test %0d random pixel sweep %s", N_TESTS,
			(errors == err_before) ? "ok" : "bad");
		$display("tests passed %0d, failed %0d, mismatches %0d", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== design/bus_pkg.sv ====
`include "tile_cfg.svh"

package bus_pkg;

	typedef logic [`WB_ADR_W-1:0] wb_adr_t;
	typedef logic [`WB_DAT_W-1:0] wb_dat_t;	// tile code in [2:0]

	// slave handshake states
	typedef enum logic [1:0] {
		WB_IDLE,
		WB_ACK,
		WB_WAIT_DROP	// stb still high after ack
	} wb_state_t;

endpackage

// ==== design/gate_timer.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module gate_timer (
	input	logic	clk,
	input	logic	resetN,
	input	logic	gate,
	output	logic	gate_open
);

	localparam int CNT_W = $clog2(`GATE_HOLD_CYCLES + 1);
	localparam logic [CNT_W-1:0] HOLD = CNT_W'(`GATE_HOLD_CYCLES);

	logic [CNT_W-1:0] count_q;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			count_q <= '0;
		else if (gate)
			count_q <= HOLD;	// a pulse while open restarts the hold
		else if (count_q != '0)
			count_q <= count_q - 1'b1;
	end

	assign gate_open = (count_q != '0);

	a_count_bound: assert property (@(posedge clk) disable iff (!resetN)
		count_q <= HOLD)
		else $error("gate count %0d above hold value", count_q);

endmodule

// ==== design/neighbor_scan.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module neighbor_scan
	import tile_pkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	coord_t	player_x,
	input	coord_t	player_y,
	input	tile_t	left_tile,
	input	tile_t	up_tile,
	input	tile_t	right_tile,
	input	tile_t	down_tile,
	output	row_t	nb_row,
	output	col_t	nb_col,
	output	tile_t	area_left,
	output	tile_t	area_up,
	output	tile_t	area_right,
	output	tile_t	area_down
);

	coord_t x_idx, y_idx;
	logic at_left, at_right, at_top, at_bottom;

	assign x_idx = player_x >> `TILE_SHIFT;
	assign y_idx = player_y >> `TILE_SHIFT;
	assign nb_row = y_idx[2:0];	// player cell
	assign nb_col = x_idx[3:0];

	assign at_left = (nb_col == '0);
	assign at_right = (nb_col == col_t'(`TILE_COLS - 1));
	assign at_top = (nb_row == '0);
	assign at_bottom = (nb_row == row_t'(`TILE_ROWS - 1));

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			area_left <= T_FREE;
			area_up <= T_FREE;
			area_right <= T_FREE;
			area_down <= T_FREE;
		end else begin
			area_left <= at_left ? T_WALL : left_tile;
			area_right <= at_right ? T_WALL : right_tile;
			area_up <= at_top ? T_WALL : up_tile;
			area_down <= at_bottom ? T_DEATH : down_tile;	// falling off the bottom
		end
	end

endmodule

// ==== design/pixel_tile_lookup.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module pixel_tile_lookup
	import tile_pkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	coord_t	pixel_x,
	input	coord_t	pixel_y,
	input	tile_t	pix_tile,
	output	row_t	pix_row,
	output	col_t	pix_col,
	output	tile_t	step_type,
	output	coord_t	tile_top_left_x,
	output	coord_t	tile_top_left_y
);

	coord_t x_idx, y_idx;
	logic in_grid;

	assign x_idx = pixel_x >> `TILE_SHIFT;
	assign y_idx = pixel_y >> `TILE_SHIFT;
	assign in_grid = (x_idx < coord_t'(`TILE_COLS)) && (y_idx < coord_t'(`TILE_ROWS));

	assign pix_row = y_idx[2:0];	// only meaningful when in_grid
	assign pix_col = x_idx[3:0];

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			step_type <= T_FREE;
			tile_top_left_x <= '0;
			tile_top_left_y <= '0;
		end else begin
			step_type <= in_grid ? pix_tile : T_WALL;
			tile_top_left_x <= x_idx << `TILE_SHIFT;	// corner even off grid
			tile_top_left_y <= y_idx << `TILE_SHIFT;
		end
	end

endmodule

// ==== design/tile_cfg.svh ====
`ifndef TILE_CFG_SVH
`define TILE_CFG_SVH

// grid geometry
`define TILE_ROWS 7
`define TILE_COLS 10
`define TILE_SHIFT 6	// 64 pixel tiles

// gate cell in the bottom row
`define GATE_ROW 6
`define GATE_COL 4
`define GATE_HOLD_CYCLES 16	// cycles the gate stays open

// wishbone widths, row in adr[6:4], column in adr[3:0]
`define WB_ADR_W 7
`define WB_DAT_W 8

`endif

// ==== design/tile_map_store.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module tile_map_store
	import tile_pkg::*;
(
	input	logic	clk,
	input	logic	resetN,
	input	row_t	pix_row,
	input	col_t	pix_col,
	input	row_t	nb_row,
	input	col_t	nb_col,
	input	logic	wr_en,
	input	row_t	wr_row,
	input	col_t	wr_col,
	input	tile_t	wr_tile,
	input	row_t	rd_row,
	input	col_t	rd_col,
	input	logic	gate_open,
	output	tile_t	pix_tile,
	output	tile_t	left_tile,
	output	tile_t	up_tile,
	output	tile_t	right_tile,
	output	tile_t	down_tile,
	output	tile_t	rd_tile
);

	localparam tile_t LEVEL [`TILE_ROWS][`TILE_COLS] = '{
		'{T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE},
		'{T_REGU, T_FREE, T_FREE, T_FREE, T_REGU, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE},
		'{T_FREE, T_FREE, T_REGU, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE},
		'{T_FREE, T_REGU, T_FREE, T_REGU, T_FREE, T_REGU, T_FREE, T_REGU, T_FREE, T_REGU},
		'{T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_REGU, T_FREE, T_FREE, T_FREE},
		'{T_REGU, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_FREE, T_REGU, T_FREE},
		'{T_FREE, T_REGU, T_REGU, T_REGU, T_FREE, T_REGU, T_FREE, T_REGU, T_FREE, T_REGU}
	};

	tile_t map_q [`TILE_ROWS][`TILE_COLS];
	row_t up_row, down_row;
	col_t left_col, right_col;

	// stored code with the gate overlay on top
	function automatic tile_t read_cell(input row_t row, input col_t col);
		tile_t code;
		if (row >= row_t'(`TILE_ROWS) || col >= col_t'(`TILE_COLS))
			code = T_WALL;	// never indexes past the array
		else if (gate_open && row == row_t'(`GATE_ROW) && col == col_t'(`GATE_COL))
			code = T_GATE;
		else
			code = map_q[row][col];
		return code;
	endfunction

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			map_q <= LEVEL;	// level is restored on every reset
		else if (wr_en)
			map_q[wr_row][wr_col] <= wr_tile;
	end

	// wrap around, neighbor_scan overrides the edges
	assign left_col = (nb_col == '0) ? col_t'(`TILE_COLS - 1) : nb_col - 1'b1;
	assign right_col = (nb_col == col_t'(`TILE_COLS - 1)) ? '0 : nb_col + 1'b1;
	assign up_row = (nb_row == '0) ? row_t'(`TILE_ROWS - 1) : nb_row - 1'b1;
	assign down_row = (nb_row == row_t'(`TILE_ROWS - 1)) ? '0 : nb_row + 1'b1;

	always_comb begin
		pix_tile = read_cell(pix_row, pix_col);
		left_tile = read_cell(nb_row, left_col);
		right_tile = read_cell(nb_row, right_col);
		up_tile = read_cell(up_row, nb_col);
		down_tile = read_cell(down_row, nb_col);
		rd_tile = read_cell(rd_row, rd_col);
	end

	// bus port must filter out-of-grid writes
	a_write_in_grid: assert property (@(posedge clk) disable iff (!resetN)
		wr_en |-> (wr_row < row_t'(`TILE_ROWS) && wr_col < col_t'(`TILE_COLS)))
		else $error("write outside the grid at row %0d col %0d", wr_row, wr_col);

endmodule

// ==== design/tile_pkg.sv ====
package tile_pkg;

	// tile code stored per cell
	typedef logic [2:0] tile_t;

	// pixel coordinate, wide enough for the whole frame
	typedef logic [10:0] coord_t;

	// grid indices
	typedef logic [2:0] row_t;
	typedef logic [3:0] col_t;

	localparam tile_t T_FREE = 3'd0;	// empty air
	localparam tile_t T_REGU = 3'd1;	// regular step
	localparam tile_t T_GATE = 3'd2;	// open gate
	localparam tile_t T_DEATH = 3'd3;	// falls out of the world
	localparam tile_t T_WALL = 3'd4;	// edges and out of grid

endpackage

// ==== design/tile_world.sv ====
`timescale 1ns/100ps

module tile_world
	import tile_pkg::*, bus_pkg::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	coord_t		pixel_x,
	input	coord_t		pixel_y,
	input	coord_t		player_x,
	input	coord_t		player_y,
	input	logic		gate,
	input	logic		wb_cyc,
	input	logic		wb_stb,
	input	logic		wb_we,
	input	wb_adr_t	wb_adr,
	input	wb_dat_t	wb_dat_w,
	output	wb_dat_t	wb_dat_r,
	output	logic		wb_ack,
	output	tile_t		step_type,
	output	coord_t		tile_top_left_x,
	output	coord_t		tile_top_left_y,
	output	tile_t [3:0]	area	// 0 left, 1 up, 2 right, 3 down
);

	row_t pix_row, nb_row, wr_row, rd_row;
	col_t pix_col, nb_col, wr_col, rd_col;
	tile_t pix_tile, left_tile, up_tile, right_tile, down_tile;
	tile_t wr_tile, rd_tile;
	logic wr_en;
	logic gate_open;

	tile_map_store tile_map_store_inst (
		.clk		(clk),
		.resetN		(resetN),
		.pix_row	(pix_row),
		.pix_col	(pix_col),
		.nb_row		(nb_row),
		.nb_col		(nb_col),
		.wr_en		(wr_en),
		.wr_row		(wr_row),
		.wr_col		(wr_col),
		.wr_tile	(wr_tile),
		.rd_row		(rd_row),
		.rd_col		(rd_col),
		.gate_open	(gate_open),
		.pix_tile	(pix_tile),
		.left_tile	(left_tile),
		.up_tile	(up_tile),
		.right_tile	(right_tile),
		.down_tile	(down_tile),
		.rd_tile	(rd_tile)
	);

	wb_tile_port wb_tile_port_inst (
		.clk		(clk),
		.resetN		(resetN),
		.wb_cyc		(wb_cyc),
		.wb_stb		(wb_stb),
		.wb_we		(wb_we),
		.wb_adr		(wb_adr),
		.wb_dat_w	(wb_dat_w),
		.rd_tile	(rd_tile),
		.wb_dat_r	(wb_dat_r),
		.wb_ack		(wb_ack),
		.wr_en		(wr_en),
		.wr_row		(wr_row),
		.wr_col		(wr_col),
		.wr_tile	(wr_tile),
		.rd_row		(rd_row),
		.rd_col		(rd_col)
	);

	gate_timer gate_timer_inst (
		.clk		(clk),
		.resetN		(resetN),
		.gate		(gate),
		.gate_open	(gate_open)
	);

	pixel_tile_lookup pixel_tile_lookup_inst (
		.clk		(clk),
		.resetN		(resetN),
		.pixel_x	(pixel_x),
		.pixel_y	(pixel_y),
		.pix_tile	(pix_tile),
		.pix_row	(pix_row),
		.pix_col	(pix_col),
		.step_type	(step_type),
		.tile_top_left_x	(tile_top_left_x),
		.tile_top_left_y	(tile_top_left_y)
	);

	neighbor_scan neighbor_scan_inst (
		.clk		(clk),
		.resetN		(resetN),
		.player_x	(player_x),
		.player_y	(player_y),
		.left_tile	(left_tile),
		.up_tile	(up_tile),
		.right_tile	(right_tile),
		.down_tile	(down_tile),
		.nb_row		(nb_row),
		.nb_col		(nb_col),
		.area_left	(area[0]),
		.area_up	(area[1]),
		.area_right	(area[2]),
		.area_down	(area[3])
	);

endmodule

// ==== design/wb_tile_port.sv ====
`timescale 1ns/100ps

`include "tile_cfg.svh"

module wb_tile_port
	import tile_pkg::*, bus_pkg::*;
(
	input	logic		clk,
	input	logic		resetN,
	input	logic		wb_cyc,
	input	logic		wb_stb,
	input	logic		wb_we,
	input	wb_adr_t	wb_adr,
	input	wb_dat_t	wb_dat_w,
	input	tile_t		rd_tile,
	output	wb_dat_t	wb_dat_r,
	output	logic		wb_ack,
	output	logic		wr_en,
	output	row_t		wr_row,
	output	col_t		wr_col,
	output	tile_t		wr_tile,
	output	row_t		rd_row,
	output	col_t		rd_col
);

	wb_state_t state_q, state_d;
	row_t adr_row;
	col_t adr_col;
	logic adr_in_grid;
	logic req;

	assign adr_row = wb_adr[`WB_ADR_W-1:4];	// upper bits pick the row
	assign adr_col = wb_adr[3:0];
	assign adr_in_grid = (adr_row < row_t'(`TILE_ROWS)) && (adr_col < col_t'(`TILE_COLS));

	assign req = (state_q == WB_IDLE) && wb_cyc && wb_stb;	// sampled only in idle

	always_comb begin
		state_d = state_q;
		case (state_q)
			WB_IDLE:	if (req) state_d = WB_ACK;
			WB_ACK:		state_d = WB_WAIT_DROP;
			WB_WAIT_DROP:	if (!wb_stb) state_d = WB_IDLE;	// master still holding
			default:	state_d = WB_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN)
			state_q <= WB_IDLE;
		else
			state_q <= state_d;
	end

	// read data held for the ack cycle
	always_ff @(posedge clk) begin
		if (req)
			wb_dat_r <= adr_in_grid ? wb_dat_t'(rd_tile) : wb_dat_t'(T_WALL);
	end

	assign wb_ack = (state_q == WB_ACK);

	// store commits on the sampling edge
	assign wr_en = req && wb_we && adr_in_grid;
	assign wr_row = adr_row;
	assign wr_col = adr_col;
	assign wr_tile = wb_dat_w[2:0];
	assign rd_row = adr_row;
	assign rd_col = adr_col;

	a_single_ack: assert property (@(posedge clk) disable iff (!resetN)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for two cycles");

endmodule

// ==== tile_world.f ====
+incdir+design
design/tile_pkg.sv
design/bus_pkg.sv
design/tile_map_store.sv
design/wb_tile_port.sv
design/gate_timer.sv
design/pixel_tile_lookup.sv
design/neighbor_scan.sv
design/tile_world.sv
bench/tb_tile_world.sv
